// ==== Makefile ====
# Verilator build and run for the scratchpad subsystem
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= mem_subsys_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_STR  ?= >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qxF '$(PASS_STR)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== mem_subsys_top.f ====
source/mem_subsys_pkg.sv
source/tdpram_core.sv
source/apb_mem_ctrl.sv
source/block_engine.sv
source/mem_subsys_top.sv
verif/mem_subsys_checker.sv
verif/mem_subsys_tb.sv

// ==== source/apb_mem_ctrl.sv ====
// APB4 slave for the scratchpad: register file, memory window on port A,
// engine start and refusal of window access while the engine is busy
`timescale 1ns/1ps

module apb_mem_ctrl import mem_subsys_pkg::*; (
   input  logic              clk_a,
   input  logic              rst_n,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [APB_AW-1:0] paddr,
   input  logic [DATA_W-1:0] pwdata,
   input  logic [STRB_W-1:0] pstrb,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   output ram_port_t         ram_a,
   input  logic [DATA_W-1:0] ram_a_rdata,
   output eng_cmd_t          eng_cmd,
   output logic              eng_start,
   input  eng_status_t       eng_stat
);

   apb_state_e        state_q;
   logic              access;                    // APB access phase
   logic              busy;
   logic              win_hit;                   // paddr inside memory window
   logic              reg_hit;                   // paddr is a known register
   logic              start_req;
   logic              mem_go;                    // port A granted this cycle
   logic              reg_wr;
   logic [DATA_W-1:0] reg_rdata;
   eng_op_e           op_q;
   logic [RAM_AW-1:0] base_q;
   logic [LEN_W-1:0]  len_q;
   logic [DATA_W-1:0] pattern_q;

   assign access    = psel && penable;
   assign busy      = eng_stat.busy;
   assign win_hit   = (paddr >= MEM_WIN_BASE) && (paddr < MEM_WIN_END);
   assign start_req = access && pwrite && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
   assign mem_go    = (state_q == APB_IDLE) && access && win_hit && !busy;
   assign eng_start = start_req && !busy;        // second start while busy is dropped
   assign reg_wr    = (state_q == APB_IDLE) && access && pwrite && !win_hit
                      && !(start_req && busy);

   always_ff @(posedge clk_a or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= APB_IDLE;
      end else begin
         case (state_q)
            APB_IDLE:    if (mem_go && !pwrite) state_q <= APB_RD_WAIT;
            APB_RD_WAIT: state_q <= APB_IDLE;    // data returned this cycle
            default:     state_q <= APB_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_a or negedge rst_n) begin
      if (!rst_n) begin
         op_q      <= OP_FILL;
         base_q    <= '0;
         len_q     <= '0;
         pattern_q <= '0;
      end else if (reg_wr) begin
         case (paddr)
            REG_CTRL:    op_q      <= eng_op_e'(pwdata[1:0]);
            REG_BASE:    base_q    <= pwdata[RAM_AW-1:0];
            REG_LEN:     len_q     <= pwdata[LEN_W-1:0];
            REG_PATTERN: pattern_q <= pwdata;
            default:     ;                       // status and sum are read only
         endcase
      end
   end

   // register read mux and decode
   always_comb begin
      reg_hit   = 1'b1;
      reg_rdata = '0;
      case (paddr)
         REG_CTRL:    reg_rdata[1:0]     = op_q;
         REG_BASE:    reg_rdata[RAM_AW-1:0] = base_q;
         REG_LEN:     reg_rdata[LEN_W-1:0]  = len_q;
         REG_PATTERN: reg_rdata          = pattern_q;
         REG_STATUS:  reg_rdata[1:0]     = {eng_stat.done, eng_stat.busy};
         REG_SUM:     reg_rdata          = eng_stat.sum;
         default:     reg_hit            = 1'b0;
      endcase
   end

   // port A request, strobes widened to a bit mask
   always_comb begin
      ram_a       = '0;
      ram_a.ce    = mem_go;
      ram_a.we    = pwrite;
      ram_a.addr  = paddr[RAM_AW+1:2];           // word index inside window
      ram_a.wdata = pwdata;
      for (int b = 0; b < STRB_W; b++)
         ram_a.wmask[8*b +: 8] = {8{pstrb[b]}};
   end

   // opcode forwarded so the engine latches the one written with start
   always_comb begin
      eng_cmd         = '0;
      eng_cmd.op      = eng_start ? eng_op_e'(pwdata[1:0]) : op_q;
      eng_cmd.base    = base_q;
      eng_cmd.len     = len_q;
      eng_cmd.pattern = pattern_q;
   end

   // APB response
   always_comb begin
      pready  = 1'b0;
      pslverr = 1'b0;
      prdata  = '0;
      if (state_q == APB_RD_WAIT) begin
         pready = 1'b1;                          // second access cycle
         prdata = ram_a_rdata;
      end else if (access) begin
         if (win_hit) begin
            if (busy) begin
               pready  = 1'b1;                   // refused, reads give zero
               pslverr = 1'b1;
            end else if (pwrite) begin
               pready = 1'b1;                    // write lands at this edge
            end
         end else begin
            pready  = 1'b1;
            pslverr = !reg_hit || (start_req && busy);
            if (!pwrite)
               prdata = reg_rdata;
         end
      end
   end

endmodule

// ==== source/block_engine.sv ====
// block engine on RAM port B: fill, incrementing fill and checksum
// over a range of words that wraps modulo the RAM depth
`timescale 1ns/1ps

module block_engine import mem_subsys_pkg::*; (
   input  logic              clk_a,
   input  logic              rst_n,
   input  eng_cmd_t          cmd,
   input  logic              start,
   output ram_port_t         ram_b,
   input  logic [DATA_W-1:0] ram_b_rdata,
   output eng_status_t       stat
);

   eng_state_e        state_q;
   eng_cmd_t          cmd_q;                     // latched at start
   logic [LEN_W-1:0]  cnt_q;                     // word index in range
   logic              done_q;
   logic              rd_vld_q;                  // ram_b_rdata valid this cycle
   logic [DATA_W-1:0] sum_q;
   logic              last_word;
   logic              go;

   assign go        = start && (state_q == ENG_IDLE);
   assign last_word = (cnt_q == cmd_q.len - LEN_W'(1));

   always_ff @(posedge clk_a) begin
      if (go)
         cmd_q <= cmd;
   end

   always_ff @(posedge clk_a or negedge rst_n) begin
      if (!rst_n) begin
         state_q  <= ENG_IDLE;
         cnt_q    <= '0;
         done_q   <= 1'b0;
         rd_vld_q <= 1'b0;
         sum_q    <= '0;
      end else begin
         rd_vld_q <= ram_b.ce && !ram_b.we;      // one-cycle read latency
         if (rd_vld_q)
            sum_q <= sum_q + ram_b_rdata;        // wraps mod 2^32
         case (state_q)
            ENG_IDLE: begin
               if (go) begin
                  cnt_q  <= '0;
                  done_q <= (cmd.len == '0);     // empty range finishes at once
                  if (cmd.op == OP_SUM)
                     sum_q <= '0;
                  if (cmd.len != '0)
                     state_q <= ENG_RUN;
               end
            end
            ENG_RUN: begin
               cnt_q <= cnt_q + LEN_W'(1);
               if (last_word) begin
                  if (cmd_q.op == OP_SUM) begin
                     state_q <= ENG_DRAIN;       // last read still returning
                  end else begin
                     state_q <= ENG_IDLE;
                     done_q  <= 1'b1;
                  end
               end
            end
            ENG_DRAIN: begin
               state_q <= ENG_IDLE;              // final word summed this cycle
               done_q  <= 1'b1;
            end
            default: state_q <= ENG_IDLE;
         endcase
      end
   end

   // port B request, address wraps in RAM_AW bits
   always_comb begin
      ram_b       = '0;
      ram_b.addr  = cmd_q.base + cnt_q[RAM_AW-1:0];
      ram_b.wmask = '1;                          // full words only
      ram_b.wdata = (cmd_q.op == OP_FILL_INCR) ? cmd_q.pattern + DATA_W'(cnt_q)
                                               : cmd_q.pattern;
      if (state_q == ENG_RUN) begin
         case (cmd_q.op)
            OP_FILL, OP_FILL_INCR: begin
               ram_b.ce = 1'b1;
               ram_b.we = 1'b1;
            end
            OP_SUM:  ram_b.ce = 1'b1;            // read
            default: ;                           // unknown op touches nothing
         endcase
      end
   end

   assign stat.busy = (state_q != ENG_IDLE);
   assign stat.done = done_q;
   assign stat.sum  = sum_q;

endmodule

// ==== source/mem_subsys_pkg.sv ====
// scratchpad subsystem shared definitions
// widths, APB register map, engine opcodes and port bundles
package mem_subsys_pkg;

   localparam int DATA_W = 32;                   // word width
   localparam int RAM_AW = 8;                    // 256 words
   localparam int APB_AW = 12;                   // APB byte address width
   localparam int STRB_W = DATA_W / 8;           // one strobe per byte
   localparam int LEN_W  = RAM_AW + 1;           // 0..256 words

   // memory window covers 256 words of 4 bytes
   localparam logic [APB_AW-1:0] MEM_WIN_BASE = 12'h400;
   localparam logic [APB_AW-1:0] MEM_WIN_END  = 12'h800;  // first byte past the window

   localparam logic [APB_AW-1:0] REG_CTRL    = 12'h000;  // op [1:0], start bit
   localparam logic [APB_AW-1:0] REG_BASE    = 12'h004;  // first word
   localparam logic [APB_AW-1:0] REG_LEN     = 12'h008;  // word count
   localparam logic [APB_AW-1:0] REG_PATTERN = 12'h00C;  // fill pattern
   localparam logic [APB_AW-1:0] REG_STATUS  = 12'h010;  // done, busy
   localparam logic [APB_AW-1:0] REG_SUM     = 12'h014;  // last checksum

   localparam int CTRL_START_BIT = 8;            // start flag in REG_CTRL writes

   typedef enum logic [1:0] {
      OP_FILL      = 2'd0,                       // constant pattern
      OP_FILL_INCR = 2'd1,                       // pattern plus word index
      OP_SUM       = 2'd2                        // checksum mod 2^32
   } eng_op_e;

   typedef enum logic [1:0] {
      ENG_IDLE  = 2'd0,
      ENG_RUN   = 2'd1,                          // one access per cycle
      ENG_DRAIN = 2'd2                           // last read returning
   } eng_state_e;

   typedef enum logic {
      APB_IDLE    = 1'b0,
      APB_RD_WAIT = 1'b1                         // window read in flight
   } apb_state_e;

   typedef struct packed {
      logic              ce;
      logic              we;
      logic [DATA_W-1:0] wmask;                  // per-bit write enable
      logic [RAM_AW-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } ram_port_t;

   typedef struct packed {
      eng_op_e           op;
      logic [RAM_AW-1:0] base;
      logic [LEN_W-1:0]  len;
      logic [DATA_W-1:0] pattern;
   } eng_cmd_t;

   typedef struct packed {
      logic              busy;
      logic              done;                   // sticky until next start
      logic [DATA_W-1:0] sum;
   } eng_status_t;

endpackage

// ==== source/mem_subsys_top.sv ====
// scratchpad subsystem top: APB control, block engine and dual-port RAM
`timescale 1ns/1ps

module mem_subsys_top import mem_subsys_pkg::*; (
   input  logic              clk_a,
   input  logic              rst_n,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [APB_AW-1:0] paddr,
   input  logic [DATA_W-1:0] pwdata,
   input  logic [STRB_W-1:0] pstrb,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr
);

   ram_port_t         ram_a;                     // APB window port
   ram_port_t         ram_b;                     // engine port
   logic [DATA_W-1:0] ram_a_rdata;
   logic [DATA_W-1:0] ram_b_rdata;
   eng_cmd_t          eng_cmd;
   logic              eng_start;
   eng_status_t       eng_stat;

   apb_mem_ctrl u_ctrl (
      .clk_a       (clk_a),
      .rst_n       (rst_n),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .paddr       (paddr),
      .pwdata      (pwdata),
      .pstrb       (pstrb),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .ram_a       (ram_a),
      .ram_a_rdata (ram_a_rdata),
      .eng_cmd     (eng_cmd),
      .eng_start   (eng_start),
      .eng_stat    (eng_stat)
   );

   block_engine u_engine (
      .clk_a       (clk_a),
      .rst_n       (rst_n),
      .cmd         (eng_cmd),
      .start       (eng_start),
      .ram_b       (ram_b),
      .ram_b_rdata (ram_b_rdata),
      .stat        (eng_stat)
   );

   tdpram_core #(
      .DW (DATA_W),
      .AW (RAM_AW)
   ) u_ram (
      .clk_a  (clk_a),
      .port_a (ram_a),
      .dout_a (ram_a_rdata),
      .port_b (ram_b),
      .dout_b (ram_b_rdata)
   );

endmodule

// ==== source/tdpram_core.sv ====
// true dual-port scratchpad RAM, bit-masked writes on both ports
// single clock, registered read on each port
`timescale 1ns/1ps

module tdpram_core import mem_subsys_pkg::*; #(
   parameter int DW = DATA_W,                    // word width
   parameter int AW = RAM_AW                     // address width
) (
   input  logic          clk_a,
   input  ram_port_t     port_a,                 // APB side
   output logic [DW-1:0] dout_a,
   input  ram_port_t     port_b,                 // engine side
   output logic [DW-1:0] dout_b
);

   logic [DW-1:0] mem [0:(1<<AW)-1];             // no reset on contents

   logic wr_a;
   logic wr_b;
   logic rd_a;
   logic rd_b;

   assign wr_a = port_a.ce && port_a.we;
   assign wr_b = port_b.ce && port_b.we;
   assign rd_a = port_a.ce && !port_a.we;
   assign rd_b = port_b.ce && !port_b.we;

   // per-bit writes, port b last so it wins a same-address clash
   always_ff @(posedge clk_a) begin
      for (int i = 0; i < DW; i++) begin
         if (wr_a && port_a.wmask[i])
            mem[port_a.addr][i] <= port_a.wdata[i];
         if (wr_b && port_b.wmask[i])
            mem[port_b.addr][i] <= port_b.wdata[i];
      end
   end

   always_ff @(posedge clk_a) begin
      if (rd_a)
         dout_a <= mem[port_a.addr];              // holds across writes
   end

   always_ff @(posedge clk_a) begin
      if (rd_b)
         dout_b <= mem[port_b.addr];
   end

endmodule

// ==== verif/mem_subsys_checker.sv ====
// APB and engine rule checks, bound into the control module
`timescale 1ns/1ps

module mem_subsys_checker import mem_subsys_pkg::*; (
   input logic              clk_a,
   input logic              rst_n,
   input logic              psel,
   input logic              penable,
   input logic              pwrite,
   input logic [APB_AW-1:0] paddr,
   input logic              pready,
   input logic              pslverr,
   input ram_port_t         ram_a,
   input logic              eng_start,
   input eng_status_t       eng_stat
);

   logic access;
   logic win;

   assign access = psel && penable;
   assign win    = (paddr >= MEM_WIN_BASE) && (paddr < MEM_WIN_END);

   // error only ends a transfer, no read left pending behind it
   err_with_ready: assert property (@(posedge clk_a) disable iff (!rst_n)
      pslverr |-> pready ##1 !pready)
      else $error("pslverr raised without pready or with a read left pending");

   // granted window read takes one wait state
   read_wait: assert property (@(posedge clk_a) disable iff (!rst_n)
      (access && !$past(access) && !pwrite && win && !eng_stat.busy)
      |-> !pready ##1 (access && pready)) else $error("window read wait state wrong");

   // port A only serves a granted window transfer, a refused one never reaches it
   win_idle: assert property (@(posedge clk_a) disable iff (!rst_n)
      ram_a.ce |-> (access && win && !pslverr))
      else $error("port A used while engine busy");

   // accepted start is an error-free write, engine answers next cycle
   start_idle: assert property (@(posedge clk_a) disable iff (!rst_n)
      eng_start |-> (access && pwrite && !pslverr) ##1 (eng_stat.busy || eng_stat.done))
      else $error("engine start while busy or without effect");

endmodule

bind apb_mem_ctrl mem_subsys_checker u_chk (.*);

// ==== verif/mem_subsys_tb.sv ====
// testbench for the scratchpad subsystem: vector driven APB traffic
// plus seeded random fills, checked against a memory model
`timescale 1ns/1ps

module mem_subsys_tb import mem_subsys_pkg::*;;

   logic              clk_a = 1'b0;
   logic              rst_n;
   logic              psel, penable, pwrite;
   logic [APB_AW-1:0] paddr;
   logic [DATA_W-1:0] pwdata;
   logic [STRB_W-1:0] pstrb;
   logic [DATA_W-1:0] prdata;
   logic              pready, pslverr;

   logic [DATA_W-1:0] model [0:255];             // predicted RAM contents
   logic [DATA_W-1:0] model_sum = '0;
   logic [RAM_AW-1:0] m_base = '0;
   logic [LEN_W-1:0]  m_len = '0;
   logic [DATA_W-1:0] m_pat = '0;
   int                mismatches = 0;
   int                failures = 0;             // timeouts, file trouble
   int                n_vec = 0;
   bit                loaded = 0;
   integer            seed = 22;
   string             v_kind[$], v_name[$];
   logic [DATA_W-1:0] v_addr[$], v_data[$], v_strb[$], v_exp[$];
   int                v_err[$];

   mem_subsys_top uut (.*);

   always #5 clk_a = ~clk_a;

   task automatic check_data(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("mismatch %s: expected %08h actual %08h", name, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_status(string name, eng_status_t exp, eng_status_t act);
      if (act !== exp) begin
         $display("mismatch %s: expected busy %0b done %0b sum %08h actual busy %0b done %0b sum %08h",
                  name, exp.busy, exp.done, exp.sum, act.busy, act.done, act.sum);
         mismatches++;
      end
   endtask

   task automatic check_err(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("mismatch %s: expected pslverr %0b actual %0b", name, exp, act);
         mismatches++;
      end
   endtask

   // one APB transfer, sampled at the falling edge
   task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                           output logic [DATA_W-1:0] rdata, output logic err);
      @(posedge clk_a);
      psel    <= 1'b1;                           // setup
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= data;
      pstrb   <= wr ? strb : '0;
      @(posedge clk_a);
      penable <= 1'b1;                           // access
      @(negedge clk_a);
      while (!pready)
         @(negedge clk_a);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk_a);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // model of an accepted engine start
   task automatic run_model(eng_op_e op);
      logic [DATA_W-1:0] s;
      logic [RAM_AW-1:0] a;
      s = '0;
      for (int i = 0; i < m_len; i++) begin
         a = m_base + RAM_AW'(i);                // wraps past 255
         case (op)
            OP_FILL:      model[a] = m_pat;
            OP_FILL_INCR: model[a] = m_pat + DATA_W'(i);
            default:      s = s + model[a];
         endcase
      end
      if (op == OP_SUM)
         model_sum = s;
   endtask

   task automatic write_op(string name, logic [APB_AW-1:0] addr, logic [DATA_W-1:0] data,
                           logic [STRB_W-1:0] strb, logic exp_err);
      logic [DATA_W-1:0] rd;
      logic              err;
      apb_xfer(1'b1, addr, data, strb, rd, err);
      check_err(name, exp_err, err);
      if (!exp_err) begin
         if (addr >= MEM_WIN_BASE) begin
            for (int b = 0; b < STRB_W; b++)
               if (strb[b]) model[addr[9:2]][8*b +: 8] = data[8*b +: 8];
         end else begin
            case (addr)
               REG_BASE:    m_base = data[RAM_AW-1:0];
               REG_LEN:     m_len = data[LEN_W-1:0];
               REG_PATTERN: m_pat = data;
               REG_CTRL:    if (data[CTRL_START_BIT]) run_model(eng_op_e'(data[1:0]));
               default:     ;
            endcase
         end
      end
   endtask

   task automatic read_op(string name, logic [APB_AW-1:0] addr, logic [DATA_W-1:0] exp,
                          logic exp_err);
      logic [DATA_W-1:0] rd;
      logic              err;
      apb_xfer(1'b0, addr, '0, '0, rd, err);
      check_err(name, exp_err, err);
      check_data(name, exp, rd);
   endtask

   // poll status until done, then compare busy, done and sum
   task automatic wait_done(string name);
      logic [DATA_W-1:0] st, sum;
      logic              err;
      bit                seen;
      eng_status_t       exp, act;
      seen = 0;
      for (int i = 0; i < 600 && !seen; i++) begin
         apb_xfer(1'b0, REG_STATUS, '0, '0, st, err);
         seen = st[1] && !st[0];
      end
      if (!seen) begin
         $display("%s: the engine did not finish in time", name);
         failures++;
      end
      apb_xfer(1'b0, REG_SUM, '0, '0, sum, err);
      exp = '{busy: 1'b0, done: 1'b1, sum: model_sum};
      act = '{busy: st[0], done: st[1], sum: sum};
      check_status(name, exp, act);
   endtask

   task automatic load_vectors();
      int    fd;
      string line, kind, name;
      logic [DATA_W-1:0] a, d, s, e;
      int    er;
      fd = $fopen("verif/mem_subsys_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file");
         failures++;
         return;
      end
      while ($fgets(line, fd)) begin
         if (line.len() < 2 || line[0] == "#")
            continue;                            // header and blank lines
         if ($sscanf(line, "%s %h %h %h %h %d %s", kind, a, d, s, e, er, name) == 7) begin
            v_kind.push_back(kind);
            v_addr.push_back(a);
            v_data.push_back(d);
            v_strb.push_back(s);
            v_exp.push_back(e);
            v_err.push_back(er);
            v_name.push_back(name);
         end
      end
      $fclose(fd);
      n_vec = v_kind.size();
   endtask

   // seeded fill, then a checksum and a word by word readback of the range
   task automatic random_block(int k);
      logic [DATA_W-1:0] base, len, pat;
      logic [RAM_AW-1:0] a;
      string             tag;
      base = $random(seed) & 32'hff;
      len  = ($random(seed) & 32'h3f) + 1;
      pat  = $random(seed);
      tag  = $sformatf("rand%0d", k);
      write_op(tag, REG_BASE, base, '1, 1'b0);
      write_op(tag, REG_LEN, len, '1, 1'b0);
      write_op(tag, REG_PATTERN, pat, '1, 1'b0);
      write_op(tag, REG_CTRL, 32'h100 | (k % 2), '1, 1'b0);
      wait_done({tag, "_fill"});
      write_op(tag, REG_CTRL, 32'h102, '1, 1'b0);
      wait_done({tag, "_sum"});
      for (int i = 0; i < len; i++) begin
         a = base[RAM_AW-1:0] + RAM_AW'(i);      // wraps past 255
         read_op($sformatf("%s_word%0d", tag, i), MEM_WIN_BASE + {2'b00, a, 2'b00},
                 model[a], 1'b0);
      end
   endtask

   initial begin
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      pstrb   = '0;
      load_vectors();
      loaded = 1;
      repeat (3) @(posedge clk_a);
      rst_n <= 1'b1;
      for (int i = 0; i < n_vec; i++) begin
         case (v_kind[i])
            "w": write_op(v_name[i], v_addr[i][APB_AW-1:0], v_data[i], v_strb[i][STRB_W-1:0],
                          v_err[i] != 0);
            "r": read_op(v_name[i], v_addr[i][APB_AW-1:0], v_exp[i], v_err[i] != 0);
            default: wait_done(v_name[i]);
         endcase
      end
      for (int k = 0; k < 4; k++)
         random_block(k);
      $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // watchdog sized from the vector count
   initial begin
      wait (loaded);
      repeat (n_vec * 300 + 2000) @(posedge clk_a);
      $display("the run did not finish before the watchdog expired");
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== verif/mem_subsys_vectors.txt ====
# kind addr data strb exp_data exp_err name  (hex except exp_err)
# kind: w = APB write, r = APB read checked against exp_data, d = wait for engine done
r 010 00000000 0 00000000 0 rst_status
r 014 00000000 0 00000000 0 rst_sum
w 400 11223344 f 00000000 0 wr_full
w 400 aabbccdd 2 00000000 0 wr_byte1
r 400 00000000 0 1122cc44 0 rd_byte1
w 7f4 0000fdfd f 00000000 0 wr_nbr_lo
w 408 00000202 f 00000000 0 wr_nbr_hi
w 004 000000fe f 00000000 0 set_base
w 008 00000004 f 00000000 0 set_len
w 00c 5a5a5a5a f 00000000 0 set_pat
w 000 00000100 f 00000000 0 start_fill
d 000 00000000 0 00000000 0 fill_done
r 7fc 00000000 0 5a5a5a5a 0 rd_fill_ff
r 404 00000000 0 5a5a5a5a 0 rd_fill_01
r 7f4 00000000 0 0000fdfd 0 rd_nbr_lo
r 408 00000000 0 00000202 0 rd_nbr_hi
w 004 00000010 f 00000000 0 set_base2
w 008 00000003 f 00000000 0 set_len3
w 00c 00000100 f 00000000 0 set_pat2
w 000 00000101 f 00000000 0 start_incr
d 000 00000000 0 00000000 0 incr_done
r 448 00000000 0 00000102 0 rd_incr_2
w 000 00000102 f 00000000 0 start_sum
d 000 00000000 0 00000000 0 sum_done
r 014 00000000 0 00000303 0 rd_sum
w 008 00000000 f 00000000 0 set_len0
w 000 00000102 f 00000000 0 start_sum0
d 000 00000000 0 00000000 0 sum0_done
w 008 00000100 f 00000000 0 set_len256
w 000 00000100 f 00000000 0 start_big
w 400 deadbeef f 00000000 1 wr_busy
r 400 00000000 0 00000000 1 rd_busy
w 000 00000102 f 00000000 1 start_busy
r 010 00000000 0 00000001 0 status_busy
d 000 00000000 0 00000000 0 big_done
r 400 00000000 0 00000100 0 rd_after_big
r 020 00000000 0 00000000 1 unmapped_rd
w 3fc 00000001 f 00000000 1 unmapped_wr
